/* ext_harness_pkg.sv */
// ****************************************
// Shared constants for the external harness
// Address map, domain count, widths and latency
// ****************************************
package ext_harness_pkg;

  // Power domains and switch-cell emulation
  localparam int unsigned NUM_DOMAINS        = 4;
  localparam int unsigned SWITCH_ACK_LATENCY = 15;

  // Register bus widths
  localparam int unsigned REG_ADDR_W = 32;
  localparam int unsigned REG_DATA_W = 32;

  // Interrupt sources
  localparam int unsigned NUM_INT_SRC   = 3;
  localparam int unsigned INT_DMA_IDX   = 0;
  localparam int unsigned INT_FIFO_IDX  = 1;
  localparam int unsigned INT_POWER_IDX = 2;

  // Peripheral address map
  localparam logic [REG_ADDR_W-1:0] POWER_CTRL_BASE = 32'h0000_0000;
  localparam logic [REG_ADDR_W-1:0] INTR_BASE       = 32'h0000_0100;
  localparam logic [REG_ADDR_W-1:0] PERIPH_SPAN     = 32'h0000_0100;

  // Power block offsets
  localparam logic [REG_ADDR_W-1:0] SWITCH_OFS = 32'h0;
  localparam logic [REG_ADDR_W-1:0] ISO_OFS    = 32'h4;
  localparam logic [REG_ADDR_W-1:0] RST_OFS    = 32'h8;
  // Read only
  localparam logic [REG_ADDR_W-1:0] ACK_OFS    = 32'hC;

  // Interrupt block offsets
  localparam logic [REG_ADDR_W-1:0] PENDING_OFS = 32'h0;
  localparam logic [REG_ADDR_W-1:0] ENABLE_OFS  = 32'h4;

endpackage

/* reg_bus_if.sv */
// ****************************************
// Register bus, one request and its response
// Host drives the request, device the response
// ****************************************
interface reg_bus_if;
  import ext_harness_pkg::*;

  logic                  valid;
  logic                  write;
  logic [REG_ADDR_W-1:0] addr;
  logic [REG_DATA_W-1:0] wdata;
  logic [REG_DATA_W-1:0] rdata;
  logic                  error;
  logic                  ready;

  modport host (
    output valid, write, addr, wdata,
    input  rdata, error, ready
  );

  modport device (
    input  valid, write, addr, wdata,
    output rdata, error, ready
  );

endinterface

/* reg_router.sv */
// ****************************************
// Address decoder and demux for the register bus
// Misses answer at once with an error
// ****************************************
module reg_router (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  req_valid_i,
  input  logic                                  req_write_i,
  input  logic [ext_harness_pkg::REG_ADDR_W-1:0] req_addr_i,
  input  logic [ext_harness_pkg::REG_DATA_W-1:0] req_wdata_i,
  output logic [ext_harness_pkg::REG_DATA_W-1:0] rsp_rdata_o,
  output logic                                  rsp_error_o,
  output logic                                  rsp_ready_o,
  reg_bus_if.host                               pwr_bus,
  reg_bus_if.host                               intr_bus
);
  import ext_harness_pkg::*;

  logic [REG_ADDR_W-1:0] pwr_ofs;
  logic [REG_ADDR_W-1:0] intr_ofs;
  logic                  pwr_sel;
  logic                  intr_sel;

  // Offset into each block doubles as the range check
  assign pwr_ofs  = req_addr_i - POWER_CTRL_BASE;
  assign intr_ofs = req_addr_i - INTR_BASE;
  assign pwr_sel  = (pwr_ofs < PERIPH_SPAN);
  assign intr_sel = (intr_ofs < PERIPH_SPAN);

  assign pwr_bus.valid  = req_valid_i & pwr_sel;
  assign pwr_bus.write  = req_write_i;
  assign pwr_bus.addr   = pwr_ofs;
  assign pwr_bus.wdata  = req_wdata_i;

  assign intr_bus.valid = req_valid_i & intr_sel;
  assign intr_bus.write = req_write_i;
  assign intr_bus.addr  = intr_ofs;
  assign intr_bus.wdata = req_wdata_i;

  always_comb begin
    if (pwr_sel) begin
      rsp_rdata_o = pwr_bus.rdata;
      rsp_error_o = pwr_bus.error;
      rsp_ready_o = pwr_bus.ready;
    end else if (intr_sel) begin
      rsp_rdata_o = intr_bus.rdata;
      rsp_error_o = intr_bus.error;
      rsp_ready_o = intr_bus.ready;
    end else begin
      // Unmapped address
      rsp_rdata_o = '0;
      rsp_error_o = 1'b1;
      rsp_ready_o = 1'b1;
    end
  end

  // Address map must not overlap
  a_one_hot_sel : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !(pwr_sel && intr_sel)
  );

endmodule

/* power_ctrl_regs.sv */
// ****************************************
// Power control registers for external domains
// Drives switch, isolation and reset per domain
// ****************************************
module power_ctrl_regs (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  reg_bus_if.device                              bus,
  input  logic [ext_harness_pkg::NUM_DOMAINS-1:0] ack_n_i,
  output logic [ext_harness_pkg::NUM_DOMAINS-1:0] switch_n_o,
  output logic [ext_harness_pkg::NUM_DOMAINS-1:0] iso_n_o,
  output logic [ext_harness_pkg::NUM_DOMAINS-1:0] domain_rst_n_o,
  output logic                                   power_done_o
);
  import ext_harness_pkg::*;

  logic [NUM_DOMAINS-1:0] switch_n_q;
  logic [NUM_DOMAINS-1:0] iso_n_q;
  logic [NUM_DOMAINS-1:0] rst_n_q;
  logic                   busy_q;
  logic                   power_done_q;
  logic                   wr_en;
  logic                   switch_wr;
  logic [NUM_DOMAINS-1:0] wr_bits;
  logic [REG_DATA_W-1:0]  rdata;

  assign wr_en     = bus.valid & bus.write;
  assign wr_bits   = bus.wdata[NUM_DOMAINS-1:0];
  assign switch_wr = wr_en && (bus.addr == SWITCH_OFS);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      switch_n_q <= '0;
      iso_n_q    <= '1;
      rst_n_q    <= '1;
    end else if (wr_en) begin
      case (bus.addr)
        SWITCH_OFS: switch_n_q <= wr_bits;
        ISO_OFS:    iso_n_q    <= wr_bits;
        RST_OFS:    rst_n_q    <= wr_bits;
        default:    ;
      endcase
    end
  end

  // Busy from a switch change until the acks catch up
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q       <= 1'b0;
      power_done_q <= 1'b0;
    end else if (switch_wr && (wr_bits != switch_n_q)) begin
      busy_q       <= 1'b1;
      power_done_q <= 1'b0;
    end else if (busy_q && (ack_n_i == switch_n_q)) begin
      busy_q       <= 1'b0;
      power_done_q <= 1'b1;
    end else begin
      power_done_q <= 1'b0;
    end
  end

  always_comb begin
    rdata = '0;
    case (bus.addr)
      SWITCH_OFS: rdata[NUM_DOMAINS-1:0] = switch_n_q;
      ISO_OFS:    rdata[NUM_DOMAINS-1:0] = iso_n_q;
      RST_OFS:    rdata[NUM_DOMAINS-1:0] = rst_n_q;
      // Live value from the switch cells
      ACK_OFS:    rdata[NUM_DOMAINS-1:0] = ack_n_i;
      default:    rdata = '0;
    endcase
  end

  assign bus.rdata = rdata;
  assign bus.error = 1'b0;
  assign bus.ready = 1'b1;

  assign switch_n_o     = switch_n_q;
  assign iso_n_o        = iso_n_q;
  assign domain_rst_n_o = rst_n_q;
  assign power_done_o   = power_done_q;

  a_done_single_pulse : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) power_done_o |=> !power_done_o
  );

endmodule

/* switch_ack_model.sv */
// ****************************************
// Power-switch cell stand-in
// Acks follow the request after a fixed delay
// ****************************************
module switch_ack_model (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic [ext_harness_pkg::NUM_DOMAINS-1:0] switch_n_i,
  output logic [ext_harness_pkg::NUM_DOMAINS-1:0] ack_n_o
);
  import ext_harness_pkg::*;

  // One stage per cycle of latency
  logic [SWITCH_ACK_LATENCY-1:0][NUM_DOMAINS-1:0] stage_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stage_q <= '0;
    end else begin
      stage_q <= {stage_q[SWITCH_ACK_LATENCY-2:0], switch_n_i};
    end
  end

  // Oldest stage is the ack
  assign ack_n_o = stage_q[SWITCH_ACK_LATENCY-1];

endmodule

/* ext_intr_regs.sv */
// ****************************************
// External interrupt collector
// Sticky pending bits masked by enable
// ****************************************
module ext_intr_regs (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  reg_bus_if.device                              bus,
  input  logic                                   dma_intr_i,
  input  logic                                   fifo_intr_i,
  input  logic                                   power_done_i,
  output logic [ext_harness_pkg::NUM_INT_SRC-1:0] intr_vector_o
);
  import ext_harness_pkg::*;

  logic [NUM_INT_SRC-1:0] src;
  logic [NUM_INT_SRC-1:0] clr;
  logic [NUM_INT_SRC-1:0] pending_q;
  logic [NUM_INT_SRC-1:0] enable_q;
  logic                   wr_en;
  logic [REG_DATA_W-1:0]  rdata;

  always_comb begin
    src                = '0;
    src[INT_DMA_IDX]   = dma_intr_i;
    src[INT_FIFO_IDX]  = fifo_intr_i;
    src[INT_POWER_IDX] = power_done_i;
  end

  assign wr_en = bus.valid & bus.write;
  // Write 1 to clear
  assign clr = (wr_en && (bus.addr == PENDING_OFS)) ? bus.wdata[NUM_INT_SRC-1:0] : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // A new event beats the clear
      pending_q <= (pending_q & ~clr) | src;
      if (wr_en && (bus.addr == ENABLE_OFS)) begin
        enable_q <= bus.wdata[NUM_INT_SRC-1:0];
      end
    end
  end

  always_comb begin
    rdata = '0;
    case (bus.addr)
      PENDING_OFS: rdata[NUM_INT_SRC-1:0] = pending_q;
      ENABLE_OFS:  rdata[NUM_INT_SRC-1:0] = enable_q;
      default:     rdata = '0;
    endcase
  end

  assign bus.rdata = rdata;
  assign bus.error = 1'b0;
  assign bus.ready = 1'b1;

  assign intr_vector_o = pending_q & enable_q;

endmodule

/* ext_harness.sv */
// ****************************************
// External register path and power emulation
// Top level with a plain register bus in and domain controls out
// ****************************************
module ext_harness (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   reg_valid_i,
  input  logic                                   reg_write_i,
  input  logic [ext_harness_pkg::REG_ADDR_W-1:0]  reg_addr_i,
  input  logic [ext_harness_pkg::REG_DATA_W-1:0]  reg_wdata_i,
  output logic [ext_harness_pkg::REG_DATA_W-1:0]  reg_rdata_o,
  output logic                                   reg_error_o,
  output logic                                   reg_ready_o,
  input  logic                                   dma_intr_i,
  input  logic                                   fifo_intr_i,
  output logic [ext_harness_pkg::NUM_DOMAINS-1:0] domain_switch_n_o,
  output logic [ext_harness_pkg::NUM_DOMAINS-1:0] domain_switch_ack_n_o,
  output logic [ext_harness_pkg::NUM_DOMAINS-1:0] domain_iso_n_o,
  output logic [ext_harness_pkg::NUM_DOMAINS-1:0] domain_rst_n_o,
  output logic [ext_harness_pkg::NUM_INT_SRC-1:0] intr_vector_o
);

  logic power_done;

  reg_bus_if pwr_bus ();
  reg_bus_if intr_bus ();

  reg_router i_reg_router (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (reg_valid_i),
    .req_write_i (reg_write_i),
    .req_addr_i  (reg_addr_i),
    .req_wdata_i (reg_wdata_i),
    .rsp_rdata_o (reg_rdata_o),
    .rsp_error_o (reg_error_o),
    .rsp_ready_o (reg_ready_o),
    .pwr_bus     (pwr_bus.host),
    .intr_bus    (intr_bus.host)
  );

  power_ctrl_regs i_power_ctrl_regs (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .bus            (pwr_bus.device),
    .ack_n_i        (domain_switch_ack_n_o),
    .switch_n_o     (domain_switch_n_o),
    .iso_n_o        (domain_iso_n_o),
    .domain_rst_n_o (domain_rst_n_o),
    .power_done_o   (power_done)
  );

  switch_ack_model i_switch_ack_model (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .switch_n_i (domain_switch_n_o),
    .ack_n_o    (domain_switch_ack_n_o)
  );

  ext_intr_regs i_ext_intr_regs (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .bus           (intr_bus.device),
    .dma_intr_i    (dma_intr_i),
    .fifo_intr_i   (fifo_intr_i),
    .power_done_i  (power_done),
    .intr_vector_o (intr_vector_o)
  );

endmodule

/* tb_ext_harness.sv */
// ****************************************
// Self-checking testbench for the external harness
// Table of register steps applied in a loop
// ****************************************
module tb_ext_harness;
  import ext_harness_pkg::*;

  localparam logic [1:0] OP_READ  = 2'd0;
  localparam logic [1:0] OP_WRITE = 2'd1;
  localparam logic [1:0] OP_PULSE = 2'd2;
  localparam logic [1:0] OP_WAIT  = 2'd3;

  localparam logic [REG_ADDR_W-1:0] SWITCH_ADDR  = POWER_CTRL_BASE + SWITCH_OFS;
  localparam logic [REG_ADDR_W-1:0] ISO_ADDR     = POWER_CTRL_BASE + ISO_OFS;
  localparam logic [REG_ADDR_W-1:0] RST_ADDR     = POWER_CTRL_BASE + RST_OFS;
  localparam logic [REG_ADDR_W-1:0] ACK_ADDR     = POWER_CTRL_BASE + ACK_OFS;
  localparam logic [REG_ADDR_W-1:0] PENDING_ADDR = INTR_BASE + PENDING_OFS;
  localparam logic [REG_ADDR_W-1:0] ENABLE_ADDR  = INTR_BASE + ENABLE_OFS;
  localparam logic [REG_ADDR_W-1:0] UNMAPPED     = 32'h0000_0200;

  // Pulse steps use data bit 0 for DMA-done and bit 1 for FIFO, wait steps the cycle count
  typedef struct packed {
    logic [1:0]             op;
    logic [REG_ADDR_W-1:0]  addr;
    logic [REG_DATA_W-1:0]  data;
    logic [REG_DATA_W-1:0]  exp_rdata;
    logic                   exp_err;
    logic [NUM_DOMAINS-1:0] exp_sw;
    logic [NUM_DOMAINS-1:0] exp_ack;
    logic [NUM_DOMAINS-1:0] exp_iso;
    logic [NUM_DOMAINS-1:0] exp_rst;
    logic [NUM_INT_SRC-1:0] exp_vec;
  } step_t;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   reg_valid_i;
  logic                   reg_write_i;
  logic [REG_ADDR_W-1:0]  reg_addr_i;
  logic [REG_DATA_W-1:0]  reg_wdata_i;
  logic [REG_DATA_W-1:0]  reg_rdata_o;
  logic                   reg_error_o;
  logic                   reg_ready_o;
  logic                   dma_intr_i;
  logic                   fifo_intr_i;
  logic [NUM_DOMAINS-1:0] domain_switch_n_o;
  logic [NUM_DOMAINS-1:0] domain_switch_ack_n_o;
  logic [NUM_DOMAINS-1:0] domain_iso_n_o;
  logic [NUM_DOMAINS-1:0] domain_rst_n_o;
  logic [NUM_INT_SRC-1:0] intr_vector_o;

  step_t       steps[$];
  int          cur_step;
  int unsigned cycle_cnt;
  int unsigned cycle_limit;

  ext_harness i_ext_harness (
    .clk_i                 (clk_i),
    .rst_n_i               (rst_n_i),
    .reg_valid_i           (reg_valid_i),
    .reg_write_i           (reg_write_i),
    .reg_addr_i            (reg_addr_i),
    .reg_wdata_i           (reg_wdata_i),
    .reg_rdata_o           (reg_rdata_o),
    .reg_error_o           (reg_error_o),
    .reg_ready_o           (reg_ready_o),
    .dma_intr_i            (dma_intr_i),
    .fifo_intr_i           (fifo_intr_i),
    .domain_switch_n_o     (domain_switch_n_o),
    .domain_switch_ack_n_o (domain_switch_ack_n_o),
    .domain_iso_n_o        (domain_iso_n_o),
    .domain_rst_n_o        (domain_rst_n_o),
    .intr_vector_o         (intr_vector_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("CHECK FAILED step %0d: %s = 0x%0h, expected 0x%0h", cur_step, name, got, exp);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic expect_read(input logic [REG_ADDR_W-1:0] addr,
                             input logic [REG_DATA_W-1:0] rdata, input logic err,
                             input logic [NUM_DOMAINS-1:0] sw, input logic [NUM_DOMAINS-1:0] ack,
                             input logic [NUM_DOMAINS-1:0] iso, input logic [NUM_DOMAINS-1:0] rst,
                             input logic [NUM_INT_SRC-1:0] vec);
    step_t s;
    s = '0;
    s.op        = OP_READ;
    s.addr      = addr;
    s.exp_rdata = rdata;
    s.exp_err   = err;
    s.exp_sw    = sw;
    s.exp_ack   = ack;
    s.exp_iso   = iso;
    s.exp_rst   = rst;
    s.exp_vec   = vec;
    steps.push_back(s);
  endtask

  task automatic queue_write(input logic [REG_ADDR_W-1:0] addr,
                             input logic [REG_DATA_W-1:0] data, input logic err);
    step_t s;
    s = '0;
    s.op      = OP_WRITE;
    s.addr    = addr;
    s.data    = data;
    s.exp_err = err;
    steps.push_back(s);
  endtask

  task automatic pulse_lines(input logic [REG_DATA_W-1:0] lines);
    step_t s;
    s = '0;
    s.op   = OP_PULSE;
    s.data = lines;
    steps.push_back(s);
  endtask

  task automatic idle_cycles(input logic [REG_DATA_W-1:0] n);
    step_t s;
    s = '0;
    s.op   = OP_WAIT;
    s.data = n;
    steps.push_back(s);
  endtask

  // Columns after the bus fields are switch_n, ack_n, iso_n, rst_n and the intr vector
  task automatic build_table();
    expect_read(SWITCH_ADDR,  32'h0, 1'b0, 4'h0, 4'h0, 4'hF, 4'hF, 3'h0);
    expect_read(ISO_ADDR,     32'hF, 1'b0, 4'h0, 4'h0, 4'hF, 4'hF, 3'h0);
    expect_read(RST_ADDR,     32'hF, 1'b0, 4'h0, 4'h0, 4'hF, 4'hF, 3'h0);
    expect_read(ACK_ADDR,     32'h0, 1'b0, 4'h0, 4'h0, 4'hF, 4'hF, 3'h0);
    expect_read(PENDING_ADDR, 32'h0, 1'b0, 4'h0, 4'h0, 4'hF, 4'hF, 3'h0);
    expect_read(ENABLE_ADDR,  32'h0, 1'b0, 4'h0, 4'h0, 4'hF, 4'hF, 3'h0);
    queue_write(ENABLE_ADDR, 32'h7, 1'b0);
    // Ack returns 15 cycles after the write edge
    queue_write(SWITCH_ADDR, 32'h5, 1'b0);
    expect_read(SWITCH_ADDR,  32'h5, 1'b0, 4'h5, 4'h0, 4'hF, 4'hF, 3'h0);
    repeat (14) begin
      expect_read(ACK_ADDR,   32'h0, 1'b0, 4'h5, 4'h0, 4'hF, 4'hF, 3'h0);
    end
    expect_read(ACK_ADDR,     32'h5, 1'b0, 4'h5, 4'h5, 4'hF, 4'hF, 3'h0);
    // Power-done pulses in this cycle and pending sets one edge later
    expect_read(PENDING_ADDR, 32'h0, 1'b0, 4'h5, 4'h5, 4'hF, 4'hF, 3'h0);
    expect_read(PENDING_ADDR, 32'h4, 1'b0, 4'h5, 4'h5, 4'hF, 4'hF, 3'h4);
    queue_write(PENDING_ADDR, 32'h4, 1'b0);
    expect_read(PENDING_ADDR, 32'h0, 1'b0, 4'h5, 4'h5, 4'hF, 4'hF, 3'h0);
    queue_write(ENABLE_ADDR, 32'h2, 1'b0);
    pulse_lines(32'h1);
    expect_read(PENDING_ADDR, 32'h1, 1'b0, 4'h5, 4'h5, 4'hF, 4'hF, 3'h0);
    idle_cycles(32'd3);
    expect_read(PENDING_ADDR, 32'h1, 1'b0, 4'h5, 4'h5, 4'hF, 4'hF, 3'h0);
    pulse_lines(32'h2);
    expect_read(PENDING_ADDR, 32'h3, 1'b0, 4'h5, 4'h5, 4'hF, 4'hF, 3'h2);
    queue_write(PENDING_ADDR, 32'h3, 1'b0);
    expect_read(PENDING_ADDR, 32'h0, 1'b0, 4'h5, 4'h5, 4'hF, 4'hF, 3'h0);
    queue_write(ISO_ADDR, 32'h9, 1'b0);
    queue_write(RST_ADDR, 32'h6, 1'b0);
    expect_read(ISO_ADDR,     32'h9, 1'b0, 4'h5, 4'h5, 4'h9, 4'h6, 3'h0);
    expect_read(RST_ADDR,     32'h6, 1'b0, 4'h5, 4'h5, 4'h9, 4'h6, 3'h0);
    expect_read(UNMAPPED,     32'h0, 1'b1, 4'h5, 4'h5, 4'h9, 4'h6, 3'h0);
    queue_write(UNMAPPED, 32'hFFFF_FFFF, 1'b1);
    expect_read(SWITCH_ADDR,  32'h5, 1'b0, 4'h5, 4'h5, 4'h9, 4'h6, 3'h0);
    expect_read(ISO_ADDR,     32'h9, 1'b0, 4'h5, 4'h5, 4'h9, 4'h6, 3'h0);
    expect_read(RST_ADDR,     32'h6, 1'b0, 4'h5, 4'h5, 4'h9, 4'h6, 3'h0);
    expect_read(ACK_ADDR,     32'h5, 1'b0, 4'h5, 4'h5, 4'h9, 4'h6, 3'h0);
    expect_read(ENABLE_ADDR,  32'h2, 1'b0, 4'h5, 4'h5, 4'h9, 4'h6, 3'h0);
    expect_read(PENDING_ADDR, 32'h0, 1'b0, 4'h5, 4'h5, 4'h9, 4'h6, 3'h0);
  endtask

  task automatic drive_step(input step_t s);
    reg_valid_i <= (s.op == OP_READ) || (s.op == OP_WRITE);
    reg_write_i <= (s.op == OP_WRITE);
    reg_addr_i  <= s.addr;
    reg_wdata_i <= (s.op == OP_WRITE) ? s.data : '0;
    dma_intr_i  <= (s.op == OP_PULSE) && s.data[0];
    fifo_intr_i <= (s.op == OP_PULSE) && s.data[1];
  endtask

  task automatic check_response(input step_t s);
    assert (reg_ready_o === 1'b1)
      else report_value("reg_ready_o", 32'(reg_ready_o), 32'h1);
    assert (reg_error_o === s.exp_err)
      else report_value("reg_error_o", 32'(reg_error_o), 32'(s.exp_err));
  endtask

  task automatic check_read(input step_t s);
    assert (reg_rdata_o === s.exp_rdata)
      else report_value("reg_rdata_o", reg_rdata_o, s.exp_rdata);
    assert (domain_switch_n_o === s.exp_sw)
      else report_value("domain_switch_n_o", 32'(domain_switch_n_o), 32'(s.exp_sw));
    assert (domain_switch_ack_n_o === s.exp_ack)
      else report_value("domain_switch_ack_n_o", 32'(domain_switch_ack_n_o), 32'(s.exp_ack));
    assert (domain_iso_n_o === s.exp_iso)
      else report_value("domain_iso_n_o", 32'(domain_iso_n_o), 32'(s.exp_iso));
    assert (domain_rst_n_o === s.exp_rst)
      else report_value("domain_rst_n_o", 32'(domain_rst_n_o), 32'(s.exp_rst));
    assert (intr_vector_o === s.exp_vec)
      else report_value("intr_vector_o", 32'(intr_vector_o), 32'(s.exp_vec));
  endtask

  initial begin
    cycle_cnt = 0;
    wait (cycle_limit != 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk_i);
      cycle_cnt = cycle_cnt + 1;
    end
    $display("Timeout: the stimulus table did not finish within %0d cycles", cycle_limit);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped by the watchdog");
  end

  initial begin
    step_t       s;
    int unsigned total;
    rst_n_i     = 1'b0;
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    dma_intr_i  = 1'b0;
    fifo_intr_i = 1'b0;
    cur_step    = 0;
    cycle_limit = 0;
    build_table();
    // Reset, the final idle cycle and a little margin
    total = 4;
    foreach (steps[i]) begin
      total += (steps[i].op == OP_WAIT) ? steps[i].data : 32'd1;
    end
    cycle_limit = 2 * total;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    for (int i = 0; i < steps.size(); i++) begin
      s        = steps[i];
      cur_step = i;
      @(posedge clk_i);
      drive_step(s);
      case (s.op)
        OP_READ: begin
          @(negedge clk_i);
          check_response(s);
          check_read(s);
        end
        OP_WRITE: begin
          @(negedge clk_i);
          check_response(s);
        end
        OP_WAIT: repeat (s.data - 1) @(posedge clk_i);
        default: ;
      endcase
    end
    @(posedge clk_i);
    reg_valid_i <= 1'b0;
    reg_write_i <= 1'b0;
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* project.f */
ext_harness_pkg.sv
reg_bus_if.sv
reg_router.sv
power_ctrl_regs.sv
switch_ack_model.sv
ext_intr_regs.sv
ext_harness.sv
tb_ext_harness.sv

/* Makefile */
# Verilator build and run for the external harness testbench

TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = tb_ext_harness
FILELIST = project.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log decides pass or fail, not the simulator exit code
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "No pass line in the log"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
